//--- gunfight_io_top.f
source/arcade_pkg.sv
source/key_mapper.sv
source/player_mapper.sv
source/core_reset.sv
source/tone_mixer.sv
source/sigma_delta_dac.sv
source/mono_video.sv
source/gunfight_io_top.sv
tests/gunfight_io_tb.sv

//--- Bender.yml
package:
  name: gunfight_io

sources:
  - files:
      - source/arcade_pkg.sv
      - source/key_mapper.sv
      - source/player_mapper.sv
      - source/core_reset.sv
      - source/tone_mixer.sv
      - source/sigma_delta_dac.sv
      - source/mono_video.sv
      - source/gunfight_io_top.sv
  - target: test
    files:
      - tests/gunfight_io_tb.sv

//--- tests/gunfight_io_tb.sv
`timescale 1ns/1ps
`default_nettype none

module gunfight_io_tb;

	localparam int MAX_CYCLES = 5000; // About twice the summed phase lengths
	localparam logic [6:0][7:0] KEY_CODES = {
		arcade_pkg::SC_GUN2_DOWN, arcade_pkg::SC_GUN2_UP, arcade_pkg::SC_GUN1_DOWN,
		arcade_pkg::SC_GUN1_UP, arcade_pkg::SC_START_TWO, arcade_pkg::SC_START_ONE,
		arcade_pkg::SC_COIN
	}; // Gun keys at 3 to 6

	logic clk_sys = 1'b0;
	logic rst, key_strobe, key_pressed, reset_req, video, hs, vs;
	logic [7:0] key_code;
	logic [1:0] scanlines;
	arcade_pkg::joystick_t joy0, joy1;
	arcade_pkg::sound_ctrl_t sound;
	arcade_pkg::player_ctrl_t p1, p2, exp_p1, exp_p2;
	arcade_pkg::cabinet_t cab, exp_cab;
	arcade_pkg::rgb_t rgb, exp_rgb;
	logic core_rst_n, vga_hs, vga_vs, audio_l, audio_r;
	logic exp_hs, exp_vs, exp_odd, hs_prev;
	logic compare_on = 1'b0;
	integer seed = 97;
	int cycle_cnt = 0;
	int err_cab = 0, err_ctrl = 0, err_rgb = 0, err_bit = 0, err_count = 0;

	gunfight_io_top dut0 (
		.clk_sys(clk_sys), .rst(rst),
		.key_strobe(key_strobe), .key_pressed(key_pressed), .key_code(key_code),
		.joy0(joy0), .joy1(joy1), .reset_req(reset_req), .scanlines(scanlines),
		.video(video), .hs(hs), .vs(vs), .sound(sound),
		.p1(p1), .p2(p2), .cab(cab), .core_rst_n(core_rst_n),
		.rgb(rgb), .vga_hs(vga_hs), .vga_vs(vga_vs),
		.audio_l(audio_l), .audio_r(audio_r)
	);

	always #50 clk_sys = ~clk_sys;

	function automatic arcade_pkg::cabinet_t expect_cab(input arcade_pkg::cabinet_t cur,
			input logic [7:0] code, input logic pressed);
		arcade_pkg::cabinet_t e;
		e = cur;
		case (code)
			arcade_pkg::SC_COIN:      e.coin = pressed;
			arcade_pkg::SC_START_ONE: e.start_one = pressed;
			arcade_pkg::SC_START_TWO: e.start_two = pressed;
			arcade_pkg::SC_GUN1_UP:   e.gun1_up = pressed;
			arcade_pkg::SC_GUN1_DOWN: e.gun1_down = pressed;
			arcade_pkg::SC_GUN2_UP:   e.gun2_up = pressed;
			arcade_pkg::SC_GUN2_DOWN: e.gun2_down = pressed;
			default: e = cur;
		endcase
		return e;
	endfunction

	function automatic arcade_pkg::player_ctrl_t expect_ctrl(input arcade_pkg::joystick_t j,
			input logic gun_up, input logic gun_down);
		arcade_pkg::player_ctrl_t e;
		e = '{fire: j.fire, gun_up: gun_up, gun_down: gun_down, left: j.left,
			right: j.right, up: j.up, down: j.down};
		return e;
	endfunction

	function automatic arcade_pkg::rgb_t expect_rgb(input logic pix, input logic odd,
			input logic [1:0] sl);
		logic [5:0] lvl;
		if (!pix)
			lvl = 6'd0;
		else if (odd && sl != 2'd0)
			lvl = arcade_pkg::SCAN_LEVEL[sl]; // Dimmed line
		else
			lvl = arcade_pkg::VIDEO_FULL;
		return '{r: lvl, g: lvl, b: 6'd0};
	endfunction

	// DAC density is amplitude / 256 while the tone is high
	function automatic int expect_ones(input int amp, input int high_cycles);
		return (amp * high_cycles) / 256;
	endfunction

	task automatic check_cab(input arcade_pkg::cabinet_t got, exp, input string name);
		if (got !== exp) begin
			err_cab++;
			$display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_ctrl(input arcade_pkg::player_ctrl_t got, exp, input string name);
		if (got !== exp) begin
			err_ctrl++;
			$display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_rgb(input arcade_pkg::rgb_t got, exp, input string name);
		if (got !== exp) begin
			err_rgb++;
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, exp, input string name);
		if (got !== exp) begin
			err_bit++;
			$display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input int got, lo, hi, input string name);
		if (got < lo || got > hi) begin
			err_count++;
			$display("[ERROR] %0t %s got %0d expected %0d..%0d", $time, name, got, lo, hi);
		end
	endtask

	// Cycles from the first edge without request until core_rst_n is high again
	task automatic measure_release(output int cycles);
		cycles = 0;
		do begin
			@(posedge clk_sys);
			cycles++;
			@(negedge clk_sys);
			check_bit(audio_l, 1'b0, "audio_l");
			check_bit(audio_r, 1'b0, "audio_r");
		end while (!core_rst_n && cycles <= 2 * arcade_pkg::RESET_HOLD);
	endtask

	always @(posedge clk_sys) begin
		if (rst) begin
			exp_cab <= '0;
			exp_p1  <= '0;
			exp_p2  <= '0;
			exp_rgb <= '0;
			exp_hs  <= 1'b0;
			exp_vs  <= 1'b0;
			exp_odd <= 1'b0;
			hs_prev <= 1'b0;
		end else begin
			if (key_strobe)
				exp_cab <= expect_cab(exp_cab, key_code, key_pressed);
			exp_p1  <= expect_ctrl(joy0, exp_cab.gun1_up, exp_cab.gun1_down);
			exp_p2  <= expect_ctrl(joy1, exp_cab.gun2_up, exp_cab.gun2_down);
			exp_rgb <= expect_rgb(video, exp_odd, scanlines); // Parity before this edge
			exp_hs  <= hs;
			exp_vs  <= vs;
			hs_prev <= hs;
			if (hs && !hs_prev)
				exp_odd <= ~exp_odd;
		end
	end

	always @(negedge clk_sys) begin
		if (compare_on) begin
			check_cab(cab, exp_cab, "cab");
			check_ctrl(p1, exp_p1, "p1");
			check_ctrl(p2, exp_p2, "p2");
			check_rgb(rgb, exp_rgb, "rgb");
			check_bit(vga_hs, exp_hs, "vga_hs");
			check_bit(vga_vs, exp_vs, "vga_vs");
		end
	end

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("=== FAIL ===");
			$finish;
		end
	end

	initial begin
		int n;
		int ones;
		int ones_r;
		int exp_n;
		logic [31:0] r;
		arcade_pkg::sound_ctrl_t snd;
		rst = 1'b1;
		key_strobe = 1'b0;
		key_pressed = 1'b0;
		key_code = 8'h00;
		joy0 = '0;
		joy1 = '0;
		reset_req = 1'b0;
		scanlines = 2'd0;
		video = 1'b0;
		hs = 1'b0;
		vs = 1'b0;
		sound = '0;

		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		check_cab(cab, '0, "cab");
		check_ctrl(p1, '0, "p1");
		check_ctrl(p2, '0, "p2");
		check_rgb(rgb, '0, "rgb");
		check_bit(core_rst_n, 1'b0, "core_rst_n");
		@(posedge clk_sys);
		rst <= 1'b0; // Fifth reset edge
		compare_on = 1'b1;
		measure_release(n);
		check_count(n, arcade_pkg::RESET_HOLD, arcade_pkg::RESET_HOLD, "core_rst_n after rst");

		for (int i = 0; i < 200; i++) begin
			@(posedge clk_sys);
			r = $random(seed);
			key_strobe  <= r[1:0] != 2'b00;
			key_pressed <= r[2];
			if (r[3])
				key_code <= KEY_CODES[{$random(seed)} % 7];
			else
				key_code <= r[15:8]; // Mostly unmapped
		end

		for (int i = 0; i < 150; i++) begin
			@(posedge clk_sys);
			r = $random(seed);
			joy0 <= r[7:0];
			joy1 <= r[15:8];
			key_strobe  <= r[16];
			key_pressed <= r[17];
			key_code    <= KEY_CODES[3 + r[19:18]];
		end

		@(posedge clk_sys);
		key_strobe <= 1'b0;
		reset_req  <= 1'b1;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_bit(core_rst_n, 1'b0, "core_rst_n");
		@(posedge clk_sys);
		@(posedge clk_sys);
		reset_req <= 1'b0;
		measure_release(n);
		check_count(n, arcade_pkg::RESET_HOLD, arcade_pkg::RESET_HOLD, "core_rst_n after req");

		for (int s = 0; s < 4; s++) begin
			for (int line = 0; line < 4; line++) begin
				for (int px = 0; px < 20; px++) begin
					@(posedge clk_sys);
					r = $random(seed);
					scanlines <= s[1:0];
					hs    <= px < 3;
					vs    <= line == 0 && px < 3;
					video <= r[0];
				end
			end
		end

		@(posedge clk_sys);
		video <= 1'b0;
		hs    <= 1'b0;
		vs    <= 1'b0;
		sound <= '0;
		repeat (3) @(posedge clk_sys);
		for (int i = 0; i < 1024; i++) begin
			@(negedge clk_sys);
			check_bit(audio_l, 1'b0, "audio_l");
			check_bit(audio_r, 1'b0, "audio_r");
		end

		@(posedge clk_sys);
		snd = '0;
		snd.port3[0] = 1'b1;
		sound <= snd;
		repeat (3) @(posedge clk_sys); // Let the sample reach the DAC
		ones = 0;
		ones_r = 0;
		for (int i = 0; i < 8 * int'(arcade_pkg::TONE_DIV[0]); i++) begin
			@(negedge clk_sys);
			if (audio_l)
				ones++;
			if (audio_r)
				ones_r++;
		end
		exp_n = expect_ones(int'(arcade_pkg::TONE_AMP), 4 * int'(arcade_pkg::TONE_DIV[0]));
		check_count(ones, exp_n, exp_n + 1, "audio_l ones");
		check_count(ones_r, exp_n, exp_n + 1, "audio_r ones");

		$display("Errors: cab %0d, ctrl %0d, rgb %0d, bit %0d, count %0d",
			err_cab, err_ctrl, err_rgb, err_bit, err_count);
		if (err_cab + err_ctrl + err_rgb + err_bit + err_count == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- source/gunfight_io_top.sv
`timescale 1ns/1ps
`default_nettype none

module gunfight_io_top (
	input  wire                       clk_sys,
	input  wire                       rst,
	input  wire                       key_strobe,
	input  wire                       key_pressed,
	input  wire [7:0]                 key_code,
	input  arcade_pkg::joystick_t     joy0,
	input  arcade_pkg::joystick_t     joy1,
	input  wire                       reset_req,
	input  wire [1:0]                 scanlines,
	input  wire                       video,
	input  wire                       hs,
	input  wire                       vs,
	input  arcade_pkg::sound_ctrl_t   sound,
	output arcade_pkg::player_ctrl_t  p1,
	output arcade_pkg::player_ctrl_t  p2,
	output arcade_pkg::cabinet_t      cab,
	output wire                       core_rst_n,
	output arcade_pkg::rgb_t          rgb,
	output wire                       vga_hs,
	output wire                       vga_vs,
	output wire                       audio_l,
	output wire                       audio_r
);

	wire [arcade_pkg::SAMPLE_W-1:0] sample;

	key_mapper key_mapper0 (
		.clk_sys(clk_sys), .rst(rst),
		.key_strobe(key_strobe), .key_pressed(key_pressed), .key_code(key_code),
		.cab(cab)
	);

	player_mapper player_mapper0 (
		.clk_sys(clk_sys), .rst(rst),
		.joy0(joy0), .joy1(joy1), .cab(cab),
		.p1(p1), .p2(p2)
	);

	core_reset core_reset0 (
		.clk_sys(clk_sys), .rst(rst),
		.reset_req(reset_req), .core_rst_n(core_rst_n)
	);

	tone_mixer tone_mixer0 (
		.clk_sys(clk_sys), .rst(rst),
		.sound(sound), .sample(sample)
	);

	sigma_delta_dac sigma_delta_dac0 (
		.clk_sys(clk_sys), .rst(rst),
		.sample(sample), .dac_out(audio_l)
	);

	assign audio_r = audio_l; // Mono cabinet

	mono_video mono_video0 (
		.clk_sys(clk_sys), .rst(rst),
		.video(video), .hs(hs), .vs(vs), .scanlines(scanlines),
		.rgb(rgb), .vga_hs(vga_hs), .vga_vs(vga_vs)
	);

endmodule

`default_nettype wire

//--- source/mono_video.sv
`timescale 1ns/1ps
`default_nettype none

module mono_video (
	input  wire                  clk_sys,
	input  wire                  rst,
	input  wire                  video,
	input  wire                  hs,
	input  wire                  vs,
	input  wire [1:0]            scanlines,
	output arcade_pkg::rgb_t     rgb,
	output logic                 vga_hs,
	output logic                 vga_vs
);

	logic       hs_d;
	logic       line_odd;
	logic [5:0] level;

	// Line parity from hs rising edges
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			hs_d     <= 1'b0;
			line_odd <= 1'b0;
		end else begin
			hs_d <= hs;
			if (hs && !hs_d) begin
				line_odd <= ~line_odd;
			end
		end
	end

	always_comb begin
		if (!video) begin
			level = '0;
		end else if (line_odd) begin
			case (scanlines)
				2'd1: level = arcade_pkg::SCAN_LEVEL[1];
				2'd2: level = arcade_pkg::SCAN_LEVEL[2];
				2'd3: level = arcade_pkg::SCAN_LEVEL[3];
				default: level = arcade_pkg::VIDEO_FULL; // Scanlines off
			endcase
		end else begin
			level = arcade_pkg::VIDEO_FULL;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			rgb    <= '0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
		end else begin
			rgb.r  <= level;
			rgb.g  <= level;
			rgb.b  <= '0; // No blue for the yellow-white monitor look
			vga_hs <= hs;
			vga_vs <= vs;
		end
	end

endmodule

`default_nettype wire

//--- source/sigma_delta_dac.sv
`timescale 1ns/1ps
`default_nettype none

module sigma_delta_dac (
	input  wire                               clk_sys,
	input  wire                               rst,
	input  wire [arcade_pkg::SAMPLE_W-1:0]    sample,
	output logic                              dac_out
);

	localparam int W = arcade_pkg::SAMPLE_W;

	logic [W:0] acc; // Extra bit is the carry

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			acc <= '0;
		end else begin
			acc <= {1'b0, acc[W-1:0]} + {1'b0, sample};
		end
	end

	// Carry rate follows sample / 2^W
	assign dac_out = acc[W];

endmodule

`default_nettype wire

//--- source/tone_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module tone_mixer (
	input  wire                                 clk_sys,
	input  wire                                 rst,
	input  arcade_pkg::sound_ctrl_t             sound,
	output logic [arcade_pkg::SAMPLE_W-1:0]     sample
);

	localparam int N_CH = 4;

	logic [N_CH-1:0][11:0]              div_cnt;
	logic [N_CH-1:0]                    wave;
	logic [N_CH-1:0]                    ch_en;
	logic [arcade_pkg::SAMPLE_W-1:0]    mix;

	// Channel enables from the two sound ports
	assign ch_en = {sound.port5[1], sound.port5[0], sound.port3[1], sound.port3[0]};

	for (genvar ch = 0; ch < N_CH; ch++) begin : g_tone
		always_ff @(posedge clk_sys) begin
			if (rst) begin
				div_cnt[ch] <= '0;
				wave[ch]    <= 1'b0;
			end else if (div_cnt[ch] == arcade_pkg::TONE_DIV[ch] - 12'd1) begin
				div_cnt[ch] <= '0;
				wave[ch]    <= ~wave[ch]; // Half period done
			end else begin
				div_cnt[ch] <= div_cnt[ch] + 12'd1;
			end
		end
	end

	always_comb begin
		mix = '0;
		for (int i = 0; i < N_CH; i++) begin
			if (ch_en[i] && wave[i]) begin
				mix = mix + arcade_pkg::TONE_AMP;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			sample <= '0;
		end else begin
			sample <= mix;
		end
	end

	// Mix must not wrap the DAC input range
	a_no_overflow: assert property (
		@(posedge clk_sys) disable iff (rst)
		sample <= N_CH * arcade_pkg::TONE_AMP
	);

endmodule

`default_nettype wire

//--- source/core_reset.sv
`timescale 1ns/1ps
`default_nettype none

module core_reset (
	input  wire  clk_sys,
	input  wire  rst,
	input  wire  reset_req,
	output logic core_rst_n
);

	localparam int CNT_W = $clog2(arcade_pkg::RESET_HOLD + 1);

	logic [CNT_W-1:0] hold_cnt;

	always_ff @(posedge clk_sys) begin
		if (rst || reset_req) begin
			hold_cnt <= CNT_W'(arcade_pkg::RESET_HOLD); // Reload while requested
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
	end

	assign core_rst_n = (hold_cnt == '0);

	a_req_resets_core: assert property (
		@(posedge clk_sys)
		reset_req |=> !core_rst_n
	);

endmodule

`default_nettype wire

//--- source/player_mapper.sv
`timescale 1ns/1ps
`default_nettype none

module player_mapper (
	input  wire                       clk_sys,
	input  wire                       rst,
	input  arcade_pkg::joystick_t     joy0,
	input  arcade_pkg::joystick_t     joy1,
	input  arcade_pkg::cabinet_t      cab,
	output arcade_pkg::player_ctrl_t  p1,
	output arcade_pkg::player_ctrl_t  p2
);

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			p1 <= '0;
			p2 <= '0;
		end else begin
			p1.fire     <= joy0.fire;
			p1.left     <= joy0.left;
			p1.right    <= joy0.right;
			p1.up       <= joy0.up;
			p1.down     <= joy0.down;
			p1.gun_up   <= cab.gun1_up; // Gun aim only from keyboard
			p1.gun_down <= cab.gun1_down;

			p2.fire     <= joy1.fire;
			p2.left     <= joy1.left;
			p2.right    <= joy1.right;
			p2.up       <= joy1.up;
			p2.down     <= joy1.down;
			p2.gun_up   <= cab.gun2_up;
			p2.gun_down <= cab.gun2_down;
		end
	end

endmodule

`default_nettype wire

//--- source/key_mapper.sv
`timescale 1ns/1ps
`default_nettype none

module key_mapper (
	input  wire                   clk_sys,
	input  wire                   rst,
	input  wire                   key_strobe,
	input  wire                   key_pressed,
	input  wire [7:0]             key_code,
	output arcade_pkg::cabinet_t  cab
);

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cab <= '0;
		end else if (key_strobe) begin
			case (key_code)
				arcade_pkg::SC_COIN: begin
					cab.coin <= key_pressed;
				end
				arcade_pkg::SC_START_ONE: begin
					cab.start_one <= key_pressed;
				end
				arcade_pkg::SC_START_TWO: begin
					cab.start_two <= key_pressed;
				end
				arcade_pkg::SC_GUN1_UP: begin
					cab.gun1_up <= key_pressed;
				end
				arcade_pkg::SC_GUN1_DOWN: begin
					cab.gun1_down <= key_pressed;
				end
				arcade_pkg::SC_GUN2_UP: begin
					cab.gun2_up <= key_pressed;
				end
				arcade_pkg::SC_GUN2_DOWN: begin
					cab.gun2_down <= key_pressed;
				end
				default: begin
				end // Unmapped keys ignored
			endcase
		end
	end

	// Buttons only move on a keyboard event
	a_cab_hold: assert property (
		@(posedge clk_sys) disable iff (rst)
		!key_strobe |=> $stable(cab)
	);

endmodule

`default_nettype wire

//--- source/arcade_pkg.sv
`default_nettype none

package arcade_pkg;

	// Per-player control as seen by the game core (active high)
	typedef struct packed {
		logic fire;
		logic gun_up;
		logic gun_down;
		logic left;
		logic right;
		logic up;
		logic down;
	} player_ctrl_t;

	// Raw joystick byte from the host link with right at bit 0
	typedef struct packed {
		logic [2:0] spare;
		logic       fire;
		logic       up;
		logic       down;
		logic       left;
		logic       right;
	} joystick_t;

	typedef struct packed {
		logic coin;
		logic start_one;
		logic start_two;
		logic gun1_up;
		logic gun1_down;
		logic gun2_up;
		logic gun2_down;
	} cabinet_t;

	typedef struct packed {
		logic [5:0] port3;
		logic [5:0] port5;
	} sound_ctrl_t;

	typedef struct packed {
		logic [5:0] r;
		logic [5:0] g;
		logic [5:0] b;
	} rgb_t;

	localparam logic [7:0] SC_COIN      = 8'h76; // ESC
	localparam logic [7:0] SC_START_ONE = 8'h05; // F1
	localparam logic [7:0] SC_START_TWO = 8'h06; // F2
	localparam logic [7:0] SC_GUN1_UP   = 8'h15; // Q
	localparam logic [7:0] SC_GUN1_DOWN = 8'h35; // Y
	localparam logic [7:0] SC_GUN2_UP   = 8'h75; // Arrow up
	localparam logic [7:0] SC_GUN2_DOWN = 8'h72; // Arrow down

	localparam int RESET_HOLD = 16;

	localparam int SAMPLE_W = 8;

	// Half periods in clocks with channel 0 as the rightmost entry
	localparam logic [3:0][11:0] TONE_DIV = {12'd45, 12'd60, 12'd75, 12'd100};
	localparam logic [SAMPLE_W-1:0] TONE_AMP = 8'd60;

	localparam logic [5:0] VIDEO_FULL = 6'd63;
	localparam logic [3:1][5:0] SCAN_LEVEL = {6'd16, 6'd32, 6'd48}; // Index is scanline setting

endpackage

`default_nettype wire
